// ==== address_decoding.sv ====
// ----------------------------------------
// PET address decoder
// Chip enables plus read-only and VRAM
// mirror flags for one bus address
// ----------------------------------------
module address_decoding (
    input  pet_bus_pkg::bus_addr_t addr_i,
    output logic                   ram_enable_o,
    output logic                   io_enable_o,      // $E8xx page
    output logic                   pia1_enable_o,
    output logic                   pia2_enable_o,
    output logic                   via_enable_o,
    output logic                   crtc_enable_o,
    output logic                   is_readonly_o,    // ROM image held in RAM
    output logic                   is_mirrored_o     // VRAM, A11/A10 forced low
);
    import pet_map_pkg::*;

    logic in_ram;
    logic in_vram;
    logic in_rom;
    logic in_io;

    assign in_ram  = (addr_i <= RAM_TOP);
    assign in_vram = (addr_i >= VRAM_BASE) && (addr_i <= VRAM_TOP);
    assign in_rom  = ((addr_i >= ROM0_BASE) && (addr_i <= ROM0_TOP))
                     || ((addr_i >= ROM1_BASE) && (addr_i <= ROM1_TOP));
    assign in_io   = (addr_i[16:8] == IO_BASE[16:8]);

    assign ram_enable_o  = addr_i[16] || in_ram || in_vram || in_rom;  // Host space is all RAM
    assign io_enable_o   = in_io;
    assign is_readonly_o = in_rom;
    assign is_mirrored_o = in_vram;

    // PET decodes the I/O page partially, one address bit per chip
    assign pia1_enable_o = in_io && |(addr_i[7:0] & PIA1_BASE[7:0]);
    assign pia2_enable_o = in_io && |(addr_i[7:0] & PIA2_BASE[7:0]);
    assign via_enable_o  = in_io && |(addr_i[7:0] & VIA_BASE[7:0]);
    assign crtc_enable_o = in_io && |(addr_i[7:0] & CRTC_BASE[7:0]);

endmodule

// ==== flist.f ====
pet_bus_pkg.sv
pet_map_pkg.sv
spi_bridge.sv
timing.sv
address_decoding.sv
keyboard.sv
pi_ctl.sv
main.sv
tb_main.sv

// ==== keyboard.sv ====
// ----------------------------------------
// Keyboard matrix
// Host fills the rows; CPU reads of PIA 1
// port B return the selected row
// ----------------------------------------
module keyboard (
    input  logic                   clk_16_i,
    input  logic                   rst_n_i,
    input  pet_bus_pkg::pi_cmd_t   pi_cmd_i,
    input  logic                   pi_write_i,
    input  pet_bus_pkg::bus_addr_t cpu_addr_i,
    input  pet_bus_pkg::bus_data_t cpu_data_i,
    input  logic                   cpu_rw_n_i,
    input  logic                   cpu_enable_i,     // CPU slot with CPU running
    input  logic                   pia1_enable_i,
    output pet_bus_pkg::bus_data_t kbd_data_o,
    output logic                   kbd_enable_o      // Overrides PIA 1 on the bus
);
    import pet_bus_pkg::*;
    import pet_map_pkg::*;

    bus_data_t matrix [KBD_ROWS];  // Active low, 0 = key down
    kbd_row_t  row_sel;
    bus_addr_t host_off;           // Host address relative to row 0
    logic      pia1_access;

    assign host_off    = pi_cmd_i.addr - KBD_MATRIX_BASE;
    assign pia1_access = cpu_enable_i && pia1_enable_i;

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            matrix  <= '{default: 8'hFF};              // No keys down
            row_sel <= '0;
        end else begin
            if (pi_write_i && (host_off < KBD_ROWS))
                matrix[host_off[3:0]] <= pi_cmd_i.data;
            if (pia1_access && !cpu_rw_n_i && (cpu_addr_i == KBD_ROW_ADDR))
                row_sel <= cpu_data_i[3:0];            // Low nibble picks the row
        end
    end

    // Rows 10 to 15 do not exist
    assign kbd_data_o   = (row_sel < KBD_ROWS) ? matrix[row_sel] : 8'hFF;
    assign kbd_enable_o = pia1_access && cpu_rw_n_i && (cpu_addr_i == PIA1_PORTB_ADDR);

endmodule

// ==== main.sv ====
// ----------------------------------------
// PET bus controller top level
// Shares the system bus between CPU and
// host, decodes selects and steers drive
// ----------------------------------------
module main (
    input  logic                    clk_16_i,       // 16 MHz system clock
    input  logic                    rst_n_i,
    input  logic                    spi_sclk_i,
    input  logic                    spi_cs_ni,
    input  logic                    spi_rx_i,
    input  pet_bus_pkg::bus_addr_t  bus_addr_i,     // Sensed from the pads
    input  pet_bus_pkg::bus_data_t  bus_data_i,
    input  logic                    bus_rw_n_i,     // 0 = write
    output logic                    spi_tx_o,
    output logic                    spi_done_no,    // Low when the host access is done
    output pet_bus_pkg::bus_drive_t bus_drive_o,    // To the pad buffers
    output logic [11:10]            ram_addr_o,     // RAM A11/A10, intercepted for mirroring
    output logic                    clk_cpu_o,      // 1 MHz phase 2
    output logic                    cpu_res_n_o,
    output logic                    cpu_ready_o,
    output logic                    cpu_en_no,
    output logic                    ram_ce_no,
    output logic                    ram_oe_no,
    output logic                    ram_we_no,
    output logic                    pia1_cs2_no,
    output logic                    pia2_cs2_no,
    output logic                    via_cs2_no,
    output logic                    io_oe_no
);
    import pet_bus_pkg::*;

    pi_cmd_t   pi_cmd;
    logic      pi_valid;
    logic      pi_done;
    logic      spi_done;
    bus_data_t pi_rd_data;     // Returned to the host on its next frame
    logic      cpu_enable;
    logic      cpu_en;         // CPU slot and CPU allowed to run
    logic      pi_select;
    logic      pi_read;
    logic      pi_write;
    logic      ram_enable;
    logic      io_enable;
    logic      pia1_enable;
    logic      pia2_enable;
    logic      via_enable;
    logic      is_readonly;
    logic      is_mirrored;
    bus_data_t kbd_data;
    logic      kbd_enable;

    spi_bridge u_spi_bridge (
        .clk_16_i, .rst_n_i, .spi_sclk_i, .spi_cs_ni, .spi_rx_i, .spi_tx_o,
        .pi_rd_data_i(pi_rd_data), .pi_done_i(pi_done),
        .pi_cmd_o(pi_cmd), .pi_valid_o(pi_valid), .spi_done_o(spi_done)
    );

    timing u_timing (
        .clk_16_i, .rst_n_i, .clk_cpu_o,
        .pi_valid_i(pi_valid), .pi_rw_n_i(pi_cmd.rw_n), .cpu_enable_o(cpu_enable),
        .pi_select_o(pi_select), .pi_read_o(pi_read), .pi_write_o(pi_write),
        .pi_done_o(pi_done)
    );

    address_decoding u_decode (
        .addr_i(bus_addr_i), .ram_enable_o(ram_enable), .io_enable_o(io_enable),
        .pia1_enable_o(pia1_enable), .pia2_enable_o(pia2_enable), .via_enable_o(via_enable),
        .crtc_enable_o(),      // CRTC sits outside this controller
        .is_readonly_o(is_readonly), .is_mirrored_o(is_mirrored)
    );

    keyboard u_keyboard (
        .clk_16_i, .rst_n_i, .pi_cmd_i(pi_cmd), .pi_write_i(pi_write),
        .cpu_addr_i(bus_addr_i), .cpu_data_i(bus_data_i), .cpu_rw_n_i(bus_rw_n_i),
        .cpu_enable_i(cpu_en), .pia1_enable_i(pia1_enable),
        .kbd_data_o(kbd_data), .kbd_enable_o(kbd_enable)
    );

    pi_ctl u_pi_ctl (
        .clk_16_i, .rst_n_i, .pi_cmd_i(pi_cmd), .pi_write_i(pi_write),
        .cpu_res_n_o, .cpu_ready_o
    );

    assign cpu_en      = cpu_enable && cpu_ready_o;
    assign cpu_en_no   = ~cpu_en;
    assign spi_done_no = ~spi_done;

    // Keyboard intercept keeps PIA 1 and the I/O buffer off the data bus
    assign pia1_cs2_no = ~(pia1_enable && !kbd_enable && cpu_en);
    assign pia2_cs2_no = ~(pia2_enable && cpu_en);
    assign via_cs2_no  = ~(via_enable && cpu_en);
    assign io_oe_no    = ~(io_enable && !kbd_enable && cpu_en);

    assign ram_ce_no = ~((ram_enable && cpu_en) || pi_select);
    assign ram_oe_no = ~(pi_read || (cpu_en && bus_rw_n_i));
    assign ram_we_no = ~(pi_write || (cpu_en && !bus_rw_n_i && !is_readonly));  // ROM protected

    // Host sees all of RAM, CPU sees VRAM folded onto its first 1K
    assign ram_addr_o = pi_select   ? pi_cmd.addr[11:10] :
                        is_mirrored ? 2'b00 : bus_addr_i[11:10];

    always_comb begin
        bus_drive_o = '0;                     // Released, CPU or RAM drives
        if (pi_select) begin
            bus_drive_o.addr    = pi_cmd.addr;
            bus_drive_o.addr_oe = 1'b1;
            bus_drive_o.rw_n    = ~pi_write;
            bus_drive_o.rw_oe   = 1'b1;
        end
        if (pi_write) begin
            bus_drive_o.data    = pi_cmd.data;
            bus_drive_o.data_oe = 1'b1;
        end else if (kbd_enable) begin
            bus_drive_o.data    = kbd_data;   // Port B read answered from the matrix
            bus_drive_o.data_oe = 1'b1;
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (pi_read)
            pi_rd_data <= bus_data_i;         // Count 4 sample is the one kept
    end

endmodule

// ==== main_tests.txt ====
# op addr data sel ra (hex) data 100 = tb memory copy, 200 = not checked
# sel bits 0 ram_ce 1 pia1 2 pia2 3 via 4 io_oe, on cpu_wr bit 0 = RAM written
pi_wr  00400 05A 00 1
pi_rd  00400 05A 00 1
pi_rd  07123 100 00 0
pi_wr  08C00 0C3 00 3
pi_rd  08C00 0C3 00 3
pi_wr  1E80F 002 00 2
cpu_rd 00400 05A 01 1
cpu_rd 08C00 100 01 0
cpu_rd 0F000 100 01 0
cpu_rd 0A400 100 01 1
cpu_rd 0E820 200 14 2
cpu_rd 0E840 200 18 2
cpu_rd 0E810 200 12 2
cpu_wr 0F004 077 00 0
cpu_rd 0F004 100 01 0
cpu_wr 01234 0E1 01 0
cpu_rd 01234 0E1 01 0
pi_rd  01234 0E1 00 0
cpu_wr 08000 03C 01 0
pi_rd  08000 03C 00 0
cpu_rd 08C00 03C 01 0
pi_wr  1E803 0A5 00 2
cpu_wr 0E810 003 00 2
cpu_rd 0E812 0A5 00 2
cpu_wr 0E810 00C 00 2
cpu_rd 0E812 0FF 00 2

// ==== pet_bus_pkg.sv ====
// ----------------------------------------
// PET system bus types
// Address and data widths, the pending host
// command and the controller's bus drive set
// ----------------------------------------
package pet_bus_pkg;

    typedef logic [16:0] bus_addr_t;    // Bit 16 selects host-only space
    typedef logic [7:0]  bus_data_t;
    typedef logic [3:0]  slot_cnt_t;    // Position within the 16-cycle frame

    // Host command as assembled by the SPI bridge
    typedef struct packed {
        logic      rw_n;                // 1 = host read, 0 = host write
        bus_addr_t addr;
        bus_data_t data;                // Write data, unused on reads
    } pi_cmd_t;

    // What the controller puts on the shared bus, each with its own enable
    typedef struct packed {
        bus_addr_t addr;
        logic      addr_oe;
        bus_data_t data;
        logic      data_oe;
        logic      rw_n;
        logic      rw_oe;
    } bus_drive_t;

endpackage

// ==== pet_map_pkg.sv ====
// ----------------------------------------
// PET memory map
// RAM, VRAM, ROM and I/O ranges plus the
// host keyboard and control registers
// ----------------------------------------
package pet_map_pkg;

    localparam pet_bus_pkg::bus_addr_t RAM_TOP         = 17'h0_7FFF;
    localparam pet_bus_pkg::bus_addr_t VRAM_BASE       = 17'h0_8000;
    localparam pet_bus_pkg::bus_addr_t VRAM_TOP        = 17'h0_8FFF;  // 4K window, mirrored
    localparam pet_bus_pkg::bus_addr_t ROM0_BASE       = 17'h0_9000;
    localparam pet_bus_pkg::bus_addr_t ROM0_TOP        = 17'h0_E7FF;
    localparam pet_bus_pkg::bus_addr_t ROM1_BASE       = 17'h0_F000;  // Kernal
    localparam pet_bus_pkg::bus_addr_t ROM1_TOP        = 17'h0_FFFF;
    localparam pet_bus_pkg::bus_addr_t IO_BASE         = 17'h0_E800;  // One 256 byte page
    localparam pet_bus_pkg::bus_addr_t PIA1_BASE       = 17'h0_E810;
    localparam pet_bus_pkg::bus_addr_t PIA2_BASE       = 17'h0_E820;
    localparam pet_bus_pkg::bus_addr_t VIA_BASE        = 17'h0_E840;
    localparam pet_bus_pkg::bus_addr_t CRTC_BASE       = 17'h0_E880;
    localparam pet_bus_pkg::bus_addr_t KBD_ROW_ADDR    = 17'h0_E810;  // PIA 1 port A
    localparam pet_bus_pkg::bus_addr_t PIA1_PORTB_ADDR = 17'h0_E812;
    localparam pet_bus_pkg::bus_addr_t KBD_MATRIX_BASE = 17'h1_E800;  // Host side only
    localparam pet_bus_pkg::bus_addr_t CTL_ADDR        = 17'h1_E80F;
    localparam int                     KBD_ROWS        = 10;

    typedef logic [3:0] kbd_row_t;      // Row select from the PIA 1 port A nibble

    // Host control register, low two bits of CTL_ADDR
    typedef struct packed {
        logic run;                      // Drives CPU ready
        logic hold_reset;               // Holds CPU reset asserted
    } ctl_bits_t;

endpackage

// ==== pi_ctl.sv ====
// ----------------------------------------
// Host control register
// Holds the CPU reset and ready lines
// ----------------------------------------
module pi_ctl (
    input  logic                 clk_16_i,
    input  logic                 rst_n_i,
    input  pet_bus_pkg::pi_cmd_t pi_cmd_i,
    input  logic                 pi_write_i,
    output logic                 cpu_res_n_o,
    output logic                 cpu_ready_o     // 1 = run, 0 = halt
);
    import pet_map_pkg::*;

    ctl_bits_t ctl_q;

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i)
            ctl_q <= '{run: 1'b0, hold_reset: 1'b1};  // CPU held until the host lets go
        else if (pi_write_i && (pi_cmd_i.addr == CTL_ADDR))
            ctl_q <= ctl_bits_t'(pi_cmd_i.data[1:0]);
    end

    assign cpu_res_n_o = ~ctl_q.hold_reset;
    assign cpu_ready_o = ctl_q.run;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PET bus controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_main -f flist.f -o tb_main
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_main > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1

// ==== spi_bridge.sv ====
// ----------------------------------------
// SPI mode-0 slave for the host link
// Builds read/write commands, returns the
// byte from the previous read in byte 0
// ----------------------------------------
module spi_bridge (
    input  logic                   clk_16_i,       // 16 MHz system clock
    input  logic                   rst_n_i,
    input  logic                   spi_sclk_i,     // Host SCLK, asynchronous
    input  logic                   spi_cs_ni,
    input  logic                   spi_rx_i,       // MOSI
    input  pet_bus_pkg::bus_data_t pi_rd_data_i,   // Byte captured by the last host read
    input  logic                   pi_done_i,      // Host slot finished
    output logic                   spi_tx_o,       // MISO
    output pet_bus_pkg::pi_cmd_t   pi_cmd_o,
    output logic                   pi_valid_o,     // Command pending until done
    output logic                   spi_done_o
);
    import pet_bus_pkg::*;

    logic [2:0]  sclk_q;        // Two sync stages plus edge history
    logic [2:0]  cs_q;
    logic [1:0]  rx_q;          // Same depth as sclk so data lines up with the edge
    logic [2:0]  bit_cnt;
    logic [2:0]  byte_cnt;      // Saturates at 7
    logic [31:0] rx_sreg;
    bus_data_t   tx_sreg;
    logic [23:0] hdr;           // Bytes 0 to 2 of the frame
    logic        sclk_rise;
    logic        sclk_fall;
    logic        cs_fall;
    logic        cs_rise;
    logic        accept;

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign cs_fall   = ~cs_q[1] & cs_q[2];
    assign cs_rise   = cs_q[1] & ~cs_q[2];
    assign hdr       = (byte_cnt == 3'd4) ? rx_sreg[31:8] : rx_sreg[23:0];
    assign spi_tx_o  = tx_sreg[7];                // MSB first

    // Whole 3 or 4 byte frame, and nothing already waiting for the bus
    assign accept = cs_rise && !pi_valid_o && (bit_cnt == 3'd0)
                    && (byte_cnt == 3'd3 || byte_cnt == 3'd4);

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sclk_q <= '0;
            cs_q   <= '1;                          // Deselected
            rx_q   <= '0;
        end else begin
            sclk_q <= {sclk_q[1:0], spi_sclk_i};
            cs_q   <= {cs_q[1:0], spi_cs_ni};
            rx_q   <= {rx_q[0], spi_rx_i};
        end
    end

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (cs_fall) begin
            bit_cnt  <= '0;                        // New frame
            byte_cnt <= '0;
        end else if (sclk_rise && !cs_q[1]) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7 && byte_cnt != 3'd7)
                byte_cnt <= byte_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (sclk_rise && !cs_q[1])
            rx_sreg <= {rx_sreg[30:0], rx_q[1]};   // Sample on rising SCLK
    end

    // Read data goes out during byte 0, zeros after that
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i)
            tx_sreg <= '0;
        else if (cs_fall)
            tx_sreg <= pi_rd_data_i;
        else if (sclk_fall && !cs_q[1])
            tx_sreg <= {tx_sreg[6:0], 1'b0};        // Next bit ready before rising SCLK
    end

    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pi_valid_o <= 1'b0;
            spi_done_o <= 1'b0;
        end else begin
            if (pi_done_i) begin
                pi_valid_o <= 1'b0;
                spi_done_o <= 1'b1;                // Held until next CS fall
            end else if (accept) begin
                pi_valid_o <= 1'b1;
            end
            if (cs_fall)
                spi_done_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_16_i) begin
        if (accept) begin
            pi_cmd_o.rw_n <= hdr[23];              // Byte 0 bit 7
            pi_cmd_o.addr <= {hdr[16], hdr[15:0]}; // Byte 0 bit 0 is A16
            pi_cmd_o.data <= rx_sreg[7:0];         // Byte 3, meaningless on reads
        end
    end

endmodule

// ==== tb_main.sv ====
// ----------------------------------------
// Testbench for the PET bus controller
// SPI host, CPU bus driver and RAM model,
// driven from the main_tests.txt table
// ----------------------------------------
module tb_main;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [16:0] CTL_REG = 17'h1_E80F;    // Host control register
    localparam logic [16:0] KBD_PORTB = 17'h0_E812;  // PIA 1 port B

    typedef struct packed {
        logic [63:0] op;       // Operation name as read from the file
        logic [16:0] addr;
        logic [9:0]  data;     // 100 = memory copy, 200 = unchecked
        logic [7:0]  sel;
        logic [1:0]  ra;
    } test_op_t;

    logic clk_16_i, rst_n_i, spi_sclk_i, spi_cs_ni, spi_rx_i, bus_rw_n_i;
    logic [16:0] bus_addr_i;
    logic [7:0]  bus_data_i = '0;
    logic spi_tx_o, spi_done_no, clk_cpu_o, cpu_res_n_o, cpu_ready_o, cpu_en_no;
    logic ram_ce_no, ram_oe_no, ram_we_no, pia1_cs2_no, pia2_cs2_no, via_cs2_no, io_oe_no;
    logic [11:10] ram_addr_o;
    pet_bus_pkg::bus_drive_t bus_drive_o;

    logic [7:0]  ram [65536];       // RAM on the board
    logic [7:0]  exp_mem [65536];   // Expected contents
    logic [15:0] src_addr;
    logic [15:0] ram_idx;
    logic [1:0]  host_ra;           // ram_addr_o seen in the last host slot
    logic [3:0]  host_drv;          // A16, rw_oe, rw_n and data_oe during the last host strobe
    logic        rd_en;
    logic [7:0]  rd_val;
    logic [7:0]  cpu_wdata;
    test_op_t    ops[$];
    int          checks, mismatches, other_errs, cycles, limit;

    main dut (.*);

    initial begin
        clk_16_i = 1'b0;
        forever #10 clk_16_i = ~clk_16_i;
    end

    // Timeout guard armed once the table is loaded
    always @(posedge clk_16_i) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // RAM answers only with its chip enable low; A11/A10 come from ram_addr_o
    always @(negedge clk_16_i) begin
        src_addr = bus_drive_o.addr_oe ? bus_drive_o.addr[15:0] : bus_addr_i[15:0];
        ram_idx  = {src_addr[15:12], ram_addr_o, src_addr[9:0]};
        if (bus_drive_o.addr_oe)
            host_ra = ram_addr_o;
        if (bus_drive_o.addr_oe && !(ram_oe_no && ram_we_no))
            host_drv = {bus_drive_o.addr[16], bus_drive_o.rw_oe, bus_drive_o.rw_n,
                        bus_drive_o.data_oe};
        rd_en  = !ram_ce_no && !ram_oe_no;
        rd_val = ram[ram_idx];
        if (!ram_ce_no && !ram_we_no)
            ram[ram_idx] = bus_drive_o.data_oe ? bus_drive_o.data : bus_data_i;
    end

    always @(posedge clk_16_i)
        bus_data_i <= rd_en ? rd_val : cpu_wdata;   // CPU data when RAM is quiet

    function automatic logic [15:0] mirror_addr(input logic [16:0] a);
        if (a >= 17'h0_8000 && a <= 17'h0_8FFF)
            return {a[15:12], 2'b00, a[9:0]};       // CPU sees VRAM folded onto 1K
        return a[15:0];
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Sends one mode-0 frame MSB first, returns MISO byte 0 and waits for done
    task automatic spi_frame(input int nbytes, input logic [31:0] bits, output logic [7:0] miso);
        miso = '0;
        @(posedge clk_16_i);
        spi_cs_ni <= 1'b0;
        repeat (6) @(posedge clk_16_i);
        for (int i = 0; i < nbytes * 8; i++) begin
            spi_rx_i <= bits[31 - i];
            repeat (4) @(posedge clk_16_i);
            @(negedge clk_16_i);
            if (i < 8)
                miso = {miso[6:0], spi_tx_o};
            @(posedge clk_16_i);
            spi_sclk_i <= 1'b1;
            repeat (4) @(posedge clk_16_i);
            spi_sclk_i <= 1'b0;
            repeat (4) @(posedge clk_16_i);
        end
        spi_cs_ni <= 1'b1;
        do @(negedge clk_16_i); while (spi_done_no);
    endtask

    task automatic host_write(input logic [16:0] a, input logic [7:0] d, input logic [1:0] ra);
        logic [7:0] rx;
        spi_frame(4, {1'b0, 6'd0, a[16], a[15:0], d}, rx);
        exp_mem[a[15:0]] = d;
        compare_value("ram model byte", ram[a[15:0]], d);
        compare_value("host ram_addr_o", host_ra, ra);
        compare_value("host bus_drive_o on write", host_drv, {a[16], 3'b101});
        if (a == CTL_REG) begin
            compare_value("cpu_res_n_o", cpu_res_n_o, !d[0]);
            compare_value("cpu_ready_o", cpu_ready_o, d[1]);
        end
    endtask

    // Data of a read comes back in byte 0 of the next frame
    task automatic host_read(input logic [16:0] a, input logic [9:0] d, input logic [1:0] ra);
        logic [7:0] rx;
        logic [7:0] exp_d;
        exp_d = (d == 10'h100) ? exp_mem[a[15:0]] : d[7:0];
        spi_frame(3, {1'b1, 6'd0, a[16], a[15:0], 8'h00}, rx);
        spi_frame(3, {1'b1, 6'd0, a[16], a[15:0], 8'h00}, rx);
        compare_value("spi_tx_o read byte", rx, exp_d);
        compare_value("host ram_addr_o", host_ra, ra);
        compare_value("host bus_drive_o on read", host_drv, {a[16], 3'b110});
    endtask

    task automatic cpu_access(input logic rw_n, input test_op_t t);
        logic [7:0] exp_d;
        logic [4:0] active;
        exp_d = (t.data == 10'h100) ? exp_mem[mirror_addr(t.addr)] : t.data[7:0];
        do @(negedge clk_16_i); while (clk_cpu_o);      // Address set up in phase 1
        compare_value("cpu_en_no in phase 1", cpu_en_no, 1'b1);
        @(posedge clk_16_i);
        bus_addr_i <= t.addr;
        bus_rw_n_i <= rw_n;
        cpu_wdata  <= rw_n ? ~exp_d : t.data[7:0];      // Inverse byte when RAM stays off
        do @(negedge clk_16_i); while (!clk_cpu_o);
        repeat (3) @(negedge clk_16_i);                 // Mid phase 2
        active = {~io_oe_no, ~via_cs2_no, ~pia2_cs2_no, ~pia1_cs2_no, ~ram_ce_no};
        compare_value("cpu_en_no in phase 2", cpu_en_no, 1'b0);
        compare_value("ram_addr_o", ram_addr_o, t.ra);
        if (rw_n) begin
            compare_value("chip selects", active, t.sel[4:0]);
            if (t.addr == KBD_PORTB) begin
                compare_value("bus_drive_o.data_oe", bus_drive_o.data_oe, 1'b1);
                compare_value("bus_drive_o.data", bus_drive_o.data, exp_d);
            end else if (t.data != 10'h200) begin
                compare_value("ram read data", bus_data_i, exp_d);
            end
        end else begin
            compare_value("ram write strobe", !ram_ce_no && !ram_we_no, t.sel[0]);
            if (t.addr <= 17'h0_8FFF)
                exp_mem[mirror_addr(t.addr)] = t.data[7:0];   // ROM stays untouched
        end
        do @(negedge clk_16_i); while (clk_cpu_o);
        @(posedge clk_16_i);
        bus_rw_n_i <= 1'b1;                             // Park as a read
    endtask

    initial begin
        int          fd;
        logic [63:0] op;
        logic [16:0] a;
        logic [9:0]  d;
        logic [7:0]  s;
        logic [1:0]  r;
        logic [8*120-1:0] skip;
        test_op_t    t;
        {rst_n_i, spi_sclk_i, spi_rx_i, bus_addr_i} = '0;
        {spi_cs_ni, bus_rw_n_i} = 2'b11;
        {checks, mismatches, other_errs, cycles, limit} = '0;
        {rd_en, cpu_wdata} = '0;
        void'($urandom(56589));
        for (int i = 0; i < 65536; i++) begin
            ram[i]     = 8'($urandom);
            exp_mem[i] = ram[i];
        end
        fd = $fopen("main_tests.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("cannot open main_tests.txt");
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(skip, fd));            // Comment line
                end else if ($fscanf(fd, "%h %h %h %h", a, d, s, r) == 4) begin
                    t.op = op;
                    t.addr = a;
                    t.data = d;
                    t.sel = s;
                    t.ra = r;
                    ops.push_back(t);
                end else begin
                    other_errs++;
                    $display("test file has a malformed line after entry %0d", ops.size());
                    break;
                end
            end
            $fclose(fd);
        end
        limit = ops.size() * 2000;
        repeat (7) @(posedge clk_16_i);
        @(negedge clk_16_i);
        compare_value("drive enables in reset",
                      {bus_drive_o.addr_oe, bus_drive_o.data_oe, bus_drive_o.rw_oe}, 0);
        compare_value("strobes in reset", {ram_ce_no, ram_oe_no, ram_we_no, pia1_cs2_no,
                      pia2_cs2_no, via_cs2_no, io_oe_no, cpu_en_no, spi_done_no}, 9'h1FF);
        compare_value("cpu reset and ready in reset", {cpu_res_n_o, cpu_ready_o}, 0);
        @(posedge clk_16_i);
        rst_n_i <= 1'b1;
        foreach (ops[k]) begin
            if (ops[k].op == "pi_wr")
                host_write(ops[k].addr, ops[k].data[7:0], ops[k].ra);
            else if (ops[k].op == "pi_rd")
                host_read(ops[k].addr, ops[k].data, ops[k].ra);
            else if (ops[k].op == "cpu_rd")
                cpu_access(1'b1, ops[k]);
            else if (ops[k].op == "cpu_wr")
                cpu_access(1'b0, ops[k]);
            else begin
                other_errs++;
                $display("entry %0d of the test file has an unknown operation", k + 1);
            end
        end
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== timing.sv ====
// ----------------------------------------
// Bus slot timer
// 16-cycle frame: host slot at counts 2-5,
// CPU slot and phase 2 at counts 8-15
// ----------------------------------------
module timing (
    input  logic clk_16_i,          // 16 MHz system clock
    input  logic rst_n_i,
    input  logic pi_valid_i,        // Host command pending
    input  logic pi_rw_n_i,
    output logic clk_cpu_o,         // 1 MHz CPU clock
    output logic cpu_enable_o,      // CPU owns the bus
    output logic pi_select_o,       // Host owns the bus
    output logic pi_read_o,
    output logic pi_write_o,
    output logic pi_done_o          // One clock at count 5
);
    import pet_bus_pkg::*;

    typedef enum logic [1:0] {
        PI_IDLE,
        PI_ACCESS,                  // Counts 2 to 4
        PI_DONE                     // Count 5
    } pi_state_t;

    slot_cnt_t cnt;
    slot_cnt_t cnt_next;
    pi_state_t state;
    pi_state_t state_next;
    logic      strobe_next;         // Read/write window, counts 3 to 4

    assign cnt_next    = cnt + 4'd1;
    assign strobe_next = (state_next == PI_ACCESS) && (cnt_next != 4'd2);

    always_comb begin
        state_next = state;
        case (state)
            PI_IDLE:   if (cnt == 4'd1 && pi_valid_i) state_next = PI_ACCESS;  // Only claim point
            PI_ACCESS: if (cnt == 4'd4) state_next = PI_DONE;
            default:   state_next = PI_IDLE;
        endcase
    end

    // Outputs decoded from next values so each one comes straight off a flop
    always_ff @(posedge clk_16_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt          <= '0;
            state        <= PI_IDLE;
            clk_cpu_o    <= 1'b0;
            cpu_enable_o <= 1'b0;
            pi_select_o  <= 1'b0;
            pi_read_o    <= 1'b0;
            pi_write_o   <= 1'b0;
            pi_done_o    <= 1'b0;
        end else begin
            cnt          <= cnt_next;
            state        <= state_next;
            clk_cpu_o    <= cnt_next[3];                  // High for counts 8 to 15
            cpu_enable_o <= cnt_next[3];                  // Own flop, clock pin stays clean
            pi_select_o  <= (state_next != PI_IDLE);
            pi_read_o    <= strobe_next && pi_rw_n_i;
            pi_write_o   <= strobe_next && !pi_rw_n_i;
            pi_done_o    <= (state_next == PI_DONE);
        end
    end

endmodule
